// ==== Makefile ====
TOP := tb_bexkat_memsys

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f bexkat_memsys.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// ==== bexkat_memsys.f ====
src/bexkat_mem_pkg.sv
src/data_ram.sv
src/bus_arbiter.sv
src/fetch_unit.sv
src/mem_stage.sv
src/bexkat_memsys.sv
tests/tb_bexkat_memsys.sv

// ==== src/bexkat_mem_pkg.sv ====
package bexkat_mem_pkg;

  // decoded memory operation
  typedef enum logic [2:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE,
    OP_PUSH,
    OP_POP,
    OP_JSR,
    OP_RTS,
    OP_TRAP
  } mem_op_t;

  typedef enum logic [1:0] {
    SZ_WORD,
    SZ_HALF,
    SZ_BYTE
  } mem_size_t;

  // stack pointer update reported with the result
  typedef enum logic [1:0] {
    SP_NONE,
    SP_DEC,
    SP_INC,
    SP_TRAP
  } sp_write_t;

  typedef struct packed {
    mem_op_t     op;
    mem_size_t   size;
    logic [31:0] addr;  // effective address or jump target
    logic [31:0] data;  // store / push data
    logic [31:0] sp;    // current stack pointer
    logic [31:0] pc;    // return address
  } mem_cmd_t;

  // master side of the bus
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;   // sel[3] is bits 31:24
    logic [31:0] adr;
    logic [31:0] dat;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } bus_rsp_t;

endpackage

// ==== src/bexkat_memsys.sv ====
module bexkat_memsys
  import bexkat_mem_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 1024,
  parameter logic [31:0] RESET_PC  = 32'h0
)
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  mem_cmd_t    cmd_i,
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  logic        stall_i,
  output logic        stall_o,
  output logic [31:0] result_o,
  output logic [31:0] pc_o,
  output logic        pc_set_o,
  output sp_write_t   sp_write_o,
  output logic [31:0] ir_o,
  output logic        ir_valid_o,
  input  logic        ir_ready_i
);

  bus_req_t ms_req;
  bus_rsp_t ms_rsp;
  bus_req_t fu_req;
  bus_rsp_t fu_rsp;
  bus_req_t ram_req;
  bus_rsp_t ram_rsp;

  mem_stage mem_stage_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .stall_i     (stall_i),
    .stall_o     (stall_o),
    .result_o    (result_o),
    .pc_o        (pc_o),
    .pc_set_o    (pc_set_o),
    .sp_write_o  (sp_write_o),
    .bus_o       (ms_req),
    .bus_i       (ms_rsp)
  );

  fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .redirect_i    (pc_set_o),  // jsr, rts and trap restart the stream
    .redirect_pc_i (pc_o),
    .ir_o          (ir_o),
    .ir_valid_o    (ir_valid_o),
    .ir_ready_i    (ir_ready_i),
    .bus_o         (fu_req),
    .bus_i         (fu_rsp)
  );

  bus_arbiter bus_arbiter_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .m0_req_i (ms_req),
    .m0_rsp_o (ms_rsp),
    .m1_req_i (fu_req),
    .m1_rsp_o (fu_rsp),
    .s_req_o  (ram_req),
    .s_rsp_i  (ram_rsp)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus_i (ram_req),
    .bus_o (ram_rsp)
  );

endmodule

// ==== src/bus_arbiter.sv ====
module bus_arbiter
  import bexkat_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  bus_req_t m0_req_i,
  output bus_rsp_t m0_rsp_o,
  input  bus_req_t m1_req_i,
  output bus_rsp_t m1_rsp_o,
  output bus_req_t s_req_o,
  input  bus_rsp_t s_rsp_i
);

  logic busy_q;
  logic owner_q;    // 0 is the memory stage
  logic owner_cyc;
  logic free;
  logic start;
  logic owner;
  logic granted;

  assign owner_cyc = owner_q ? m1_req_i.cyc : m0_req_i.cyc;
  assign free = !busy_q || !owner_cyc;  // tenure ends when cyc falls
  assign start = free && (m0_req_i.cyc || m1_req_i.cyc);
  assign owner = free ? !m0_req_i.cyc : owner_q;  // master 0 first
  assign granted = start || !free;

  // a waiting master has already dropped stb, so the strobe
  // to the slave is issued once at the start of each grant
  always_comb
  begin
    s_req_o = owner ? m1_req_i : m0_req_i;
    s_req_o.stb = start;
  end

  always_comb
  begin
    m0_rsp_o = '0;
    m1_rsp_o = '0;
    if (granted && owner)
      m1_rsp_o = s_rsp_i;
    else if (granted)
      m0_rsp_o = s_rsp_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy_q <= 1'b0;
      owner_q <= 1'b0;
    end
    else
    begin
      busy_q <= granted;
      owner_q <= owner;
    end
  end

endmodule

// ==== src/data_ram.sv ====
module data_ram
  import bexkat_mem_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 1024
)
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  bus_req_t bus_i,
  output bus_rsp_t bus_o
);

  localparam int unsigned AW = $clog2(RAM_WORDS);

  logic [31:0]   mem_q [RAM_WORDS];
  logic [31:0]   rdata_q;
  logic          ack_q;
  logic          take;
  logic [AW-1:0] idx;

  // depth is a power of two, so the index wraps
  assign idx = bus_i.adr[AW+1:2];
  assign take = bus_i.cyc && bus_i.stb && !ack_q;

  assign bus_o = '{ack: ack_q, dat: rdata_q};

  initial
  begin
    for (int i = 0; i < RAM_WORDS; i++)
      mem_q[i] = 32'h0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      for (int l = 0; l < 4; l++)
        if (bus_i.we && bus_i.sel[l])
          mem_q[idx][8*l +: 8] <= bus_i.dat[8*l +: 8];
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= take;  // single cycle ack
  end

endmodule

// ==== src/fetch_unit.sv ====
module fetch_unit
  import bexkat_mem_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
)
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  output logic [31:0] ir_o,
  output logic        ir_valid_o,
  input  logic        ir_ready_i,
  output bus_req_t    bus_o,
  input  bus_rsp_t    bus_i
);

  logic [31:0] addr_q;    // next fetch address
  logic [31:0] adr_q;     // address of the read on the bus
  logic        pend_q;    // read outstanding, also cyc
  logic        stb_q;
  logic        discard_q; // drop the word of the read in flight
  logic        full_q;
  logic [31:0] ir_q;
  logic        done;
  logic        pop;
  logic        fill;
  logic        issue;

  assign done = pend_q && bus_i.ack;
  assign ir_valid_o = full_q && !redirect_i;  // old stream is hidden on redirect
  assign ir_o = ir_q;
  assign pop = ir_valid_o && ir_ready_i;
  assign fill = done && !discard_q && !redirect_i;
  assign issue = !pend_q && !redirect_i && (!full_q || pop);

  assign bus_o = '{cyc: pend_q, stb: stb_q, we: 1'b0, sel: 4'hf, adr: adr_q, dat: 32'h0};

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      addr_q <= RESET_PC;
      pend_q <= 1'b0;
      stb_q <= 1'b0;
      discard_q <= 1'b0;
      full_q <= 1'b0;
    end
    else
    begin
      stb_q <= issue;
      if (issue)
        pend_q <= 1'b1;
      else if (done)
        pend_q <= 1'b0;
      if (redirect_i)
        discard_q <= pend_q && !bus_i.ack;
      else if (done)
        discard_q <= 1'b0;
      if (redirect_i)
        full_q <= 1'b0;
      else if (fill)
        full_q <= 1'b1;
      else if (pop)
        full_q <= 1'b0;
      if (redirect_i)
        addr_q <= redirect_pc_i;
      else if (issue)
        addr_q <= addr_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
      adr_q <= addr_q;
    if (fill)
      ir_q <= bus_i.dat;
  end

endmodule

// ==== src/mem_stage.sv ====
module mem_stage
  import bexkat_mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  mem_cmd_t    cmd_i,
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  logic        stall_i,
  output logic        stall_o,
  output logic [31:0] result_o,
  output logic [31:0] pc_o,
  output logic        pc_set_o,
  output sp_write_t   sp_write_o,
  output bus_req_t    bus_o,
  input  bus_rsp_t    bus_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_STORE,
    S_PUSH,
    S_POP,
    S_JSR,
    S_RTS,
    S_TRAP
  } state_t;

  state_t      state_q, state_d;
  logic        cyc_q, cyc_d;
  logic        stb_q, stb_d;
  logic        we_q, we_d;
  logic [3:0]  sel_q, sel_d;
  logic [31:0] adr_q, adr_d;
  logic [31:0] dat_q, dat_d;
  mem_size_t   size_q, size_d;
  logic [31:0] target_q, target_d;
  logic [31:0] result_d;
  logic [31:0] pc_d;
  logic        pc_set_d;
  sp_write_t   sp_write_d;
  logic        accept;
  logic [31:0] sp_dec;
  logic [31:0] load_data;

  // big-endian lanes, lane 0 of the address is sel[3]
  function automatic logic [3:0] lane_sel(mem_size_t size, logic [1:0] lo);
    case (size)
      SZ_HALF: lane_sel = lo[1] ? 4'b0011 : 4'b1100;
      SZ_BYTE: lane_sel = 4'b1000 >> lo;
      default: lane_sel = 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] store_lanes(mem_size_t size, logic [31:0] data);
    case (size)
      SZ_HALF: store_lanes = {2{data[15:0]}};
      SZ_BYTE: store_lanes = {4{data[7:0]}};
      default: store_lanes = data;
    endcase
  endfunction

  // shift the addressed lanes down, zero-extend
  function automatic logic [31:0] load_align(mem_size_t size, logic [1:0] lo,
                                             logic [31:0] data);
    load_align = data;
    if (size == SZ_HALF)
      load_align = lo[1] ? {16'h0, data[15:0]} : {16'h0, data[31:16]};
    else if (size == SZ_BYTE)
      case (lo)
        2'b00: load_align = {24'h0, data[31:24]};
        2'b01: load_align = {24'h0, data[23:16]};
        2'b10: load_align = {24'h0, data[15:8]};
        default: load_align = {24'h0, data[7:0]};
      endcase
  endfunction

  assign stall_o = cyc_q;
  assign cmd_ready_o = (state_q == S_IDLE) && !stall_o;
  assign accept = cmd_valid_i && cmd_ready_o;
  assign sp_dec = cmd_i.sp - 32'd4;
  assign load_data = load_align(size_q, adr_q[1:0], bus_i.dat);

  assign bus_o = '{cyc: cyc_q, stb: stb_q, we: we_q, sel: sel_q, adr: adr_q, dat: dat_q};

  always_comb
  begin
    state_d = state_q;
    cyc_d = cyc_q;
    stb_d = 1'b0;  // strobe lasts one cycle
    we_d = we_q;
    sel_d = sel_q;
    adr_d = adr_q;
    dat_d = dat_q;
    size_d = size_q;
    target_d = target_q;
    result_d = result_o;
    pc_d = pc_o;
    pc_set_d = stall_i ? pc_set_o : 1'b0;
    sp_write_d = stall_i ? sp_write_o : SP_NONE;
    case (state_q)
      S_IDLE:
        if (accept)
        begin
          cyc_d = 1'b1;
          stb_d = 1'b1;
          we_d = 1'b1;
          sel_d = 4'hf;
          adr_d = sp_dec;  // stack writes go below sp
          dat_d = cmd_i.pc;
          size_d = SZ_WORD;
          target_d = cmd_i.addr;
          case (cmd_i.op)
            OP_LOAD:
            begin
              state_d = S_LOAD;
              we_d = 1'b0;
              adr_d = cmd_i.addr;
              size_d = cmd_i.size;
              sel_d = lane_sel(cmd_i.size, cmd_i.addr[1:0]);
            end
            OP_STORE:
            begin
              state_d = S_STORE;
              adr_d = cmd_i.addr;
              size_d = cmd_i.size;
              sel_d = lane_sel(cmd_i.size, cmd_i.addr[1:0]);
              dat_d = store_lanes(cmd_i.size, cmd_i.data);
            end
            OP_PUSH:
            begin
              state_d = S_PUSH;
              dat_d = cmd_i.data;
            end
            OP_POP:
            begin
              state_d = S_POP;
              we_d = 1'b0;
              adr_d = cmd_i.sp;
            end
            OP_JSR:
              state_d = S_JSR;
            OP_RTS:
            begin
              state_d = S_RTS;
              we_d = 1'b0;
              adr_d = cmd_i.sp;
            end
            OP_TRAP:
              state_d = S_TRAP;
            default:
            begin
              cyc_d = 1'b0;  // nothing to do on the bus
              stb_d = 1'b0;
            end
          endcase
        end
      default:
        if (bus_i.ack)
        begin
          state_d = S_IDLE;
          cyc_d = 1'b0;
          case (state_q)
            S_LOAD:
              result_d = load_data;
            S_POP:
            begin
              result_d = load_data;
              sp_write_d = SP_INC;
            end
            S_PUSH:
              sp_write_d = SP_DEC;
            S_JSR:
            begin
              pc_d = target_q;
              pc_set_d = 1'b1;
              sp_write_d = SP_DEC;
            end
            S_RTS:
            begin
              pc_d = bus_i.dat;  // popped return address
              pc_set_d = 1'b1;
              sp_write_d = SP_INC;
            end
            S_TRAP:
            begin
              pc_d = target_q;
              pc_set_d = 1'b1;
              sp_write_d = SP_TRAP;
            end
            default:
            begin
            end
          endcase
        end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_IDLE;
      cyc_q <= 1'b0;
      stb_q <= 1'b0;
      pc_set_o <= 1'b0;
      sp_write_o <= SP_NONE;
    end
    else
    begin
      state_q <= state_d;
      cyc_q <= cyc_d;
      stb_q <= stb_d;
      pc_set_o <= pc_set_d;
      sp_write_o <= sp_write_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    we_q <= we_d;
    sel_q <= sel_d;
    adr_q <= adr_d;
    dat_q <= dat_d;
    size_q <= size_d;
    target_q <= target_d;
    result_o <= result_d;
    pc_o <= pc_d;
  end

endmodule

// ==== tests/tb_bexkat_memsys.sv ====
module tb_bexkat_memsys
  import bexkat_mem_pkg::*;
();

  localparam int unsigned RAM_WORDS = 4096;
  localparam logic [31:0] RESET_PC = 32'h0;
  localparam logic [31:0] SEED = 32'h6033471b;
  localparam int MEM_BYTES = 4 * RAM_WORDS;
  localparam int RST_CYCLES = 8;
  localparam int NCODE = 32;   // words written into the code region
  localparam int NRAND = 120;
  localparam int LIMIT = RST_CYCLES + (NCODE + 2 * NRAND) * 64;

  logic        clk_i = 1'b0;
  logic        rst_i;
  mem_cmd_t    cmd_i;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  logic        stall_i;
  logic        stall_o;
  logic [31:0] result_o;
  logic [31:0] pc_o;
  logic        pc_set_o;
  sp_write_t   sp_write_o;
  logic [31:0] ir_o;
  logic        ir_valid_o;
  logic        ir_ready_i;

  logic [7:0]  model_mem [MEM_BYTES];   // big-endian byte image of the RAM
  logic [31:0] main_lfsr = SEED;
  logic [31:0] fetch_pc = RESET_PC;     // model fetch address
  int          taken = 0;
  logic        stream_on = 1'b0;

  bexkat_memsys #(.RAM_WORDS(RAM_WORDS), .RESET_PC(RESET_PC)) bexkat_memsys_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .stall_i     (stall_i),
    .stall_o     (stall_o),
    .result_o    (result_o),
    .pc_o        (pc_o),
    .pc_set_o    (pc_set_o),
    .sp_write_o  (sp_write_o),
    .ir_o        (ir_o),
    .ir_valid_o  (ir_valid_o),
    .ir_ready_i  (ir_ready_i)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], main_lfsr[0]};
      main_lfsr = lfsr_next(main_lfsr);
    end
    return v;
  endfunction

  function automatic mem_size_t rand_size();
    logic [1:0] r;
    r = 2'(rand_bits(2));
    rand_size = (r == 2'd3) ? SZ_WORD : mem_size_t'(r);
  endfunction

  function automatic mem_cmd_t make_cmd(input mem_op_t op, input mem_size_t size,
                                        input logic [31:0] addr, input logic [31:0] data,
                                        input logic [31:0] sp, input logic [31:0] pc);
    mem_cmd_t c;
    c.op = op;
    c.size = size;
    c.addr = addr;
    c.data = data;
    c.sp = sp;
    c.pc = pc;
    return c;
  endfunction

  // zero-extended read of the addressed bytes
  function automatic logic [31:0] model_load(input mem_size_t size, input logic [31:0] a);
    logic [13:0] w;
    logic [13:0] h;
    w = {a[13:2], 2'b00};
    h = {a[13:2], a[1], 1'b0};
    case (size)
      SZ_HALF: model_load = {16'h0, model_mem[h], model_mem[h + 14'd1]};
      SZ_BYTE: model_load = {24'h0, model_mem[a[13:0]]};
      default: model_load = {model_mem[w], model_mem[w + 14'd1],
                             model_mem[w + 14'd2], model_mem[w + 14'd3]};
    endcase
  endfunction

  function automatic void model_store(input mem_size_t size, input logic [31:0] a,
                                      input logic [31:0] d);
    logic [13:0] w;
    logic [13:0] h;
    w = {a[13:2], 2'b00};
    h = {a[13:2], a[1], 1'b0};
    case (size)
      SZ_HALF:
      begin
        model_mem[h] = d[15:8];
        model_mem[h + 14'd1] = d[7:0];
      end
      SZ_BYTE:
        model_mem[a[13:0]] = d[7:0];
      default:
      begin
        model_mem[w] = d[31:24];
        model_mem[w + 14'd1] = d[23:16];
        model_mem[w + 14'd2] = d[15:8];
        model_mem[w + 14'd3] = d[7:0];
      end
    endcase
  endfunction

  function automatic sp_write_t sp_update(input mem_op_t op);
    case (op)
      OP_PUSH, OP_JSR: sp_update = SP_DEC;
      OP_POP, OP_RTS: sp_update = SP_INC;
      OP_TRAP: sp_update = SP_TRAP;
      default: sp_update = SP_NONE;
    endcase
  endfunction

  function automatic logic redirects(input mem_op_t op);
    redirects = (op == OP_JSR) || (op == OP_RTS) || (op == OP_TRAP);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
  endtask

  task automatic check_sp(input string name, input sp_write_t exp, input sp_write_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
  endtask

  task automatic check_ir(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
  endtask

  task automatic run_cmd(input mem_cmd_t c, input string name);
    int          hold;
    logic [31:0] res_q;
    logic [31:0] pc_q;
    logic        set_q;
    sp_write_t   sp_q;
    hold = rand_bits(2);
    @(posedge clk_i);
    cmd_i <= c;
    cmd_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!cmd_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    stall_i <= (hold != 0);  // keeps the result registers frozen
    @(negedge clk_i);
    if (c.op == OP_NONE)
      check_word({name, " stall"}, 32'h0, {31'h0, stall_o});
    while (stall_o)
      @(negedge clk_i);
    case (c.op)
      OP_LOAD:
        check_word({name, " data"}, model_load(c.size, c.addr), result_o);
      OP_STORE:
        model_store(c.size, c.addr, c.data);
      OP_PUSH:
        model_store(SZ_WORD, c.sp - 32'd4, c.data);
      OP_POP:
        check_word({name, " data"}, model_load(SZ_WORD, c.sp), result_o);
      OP_JSR, OP_TRAP:
      begin
        model_store(SZ_WORD, c.sp - 32'd4, c.pc);  // return address below sp
        check_word({name, " target"}, c.addr, pc_o);
      end
      OP_RTS:
        check_word({name, " target"}, model_load(SZ_WORD, c.sp), pc_o);
      default:
      begin
      end
    endcase
    check_word({name, " pc_set"}, {31'h0, redirects(c.op)}, {31'h0, pc_set_o});
    check_sp(name, sp_update(c.op), sp_write_o);
    res_q = result_o;
    pc_q = pc_o;
    set_q = pc_set_o;
    sp_q = sp_write_o;
    for (int i = 0; i < hold; i++)
    begin
      @(posedge clk_i);
      if (i == hold - 1)
        stall_i <= 1'b0;
      @(negedge clk_i);
      check_word("stall hold result", res_q, result_o);
      check_word("stall hold pc", pc_q, pc_o);
      check_word("stall hold pc_set", {31'h0, set_q}, {31'h0, pc_set_o});
      check_sp("stall hold", sp_q, sp_write_o);
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check_word({name, " pulse end"}, 32'h0, {31'h0, pc_set_o});
    check_sp({name, " pulse end"}, SP_NONE, sp_write_o);
  endtask

  // instruction stream against the model fetch address
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (pc_set_o)
        fetch_pc <= pc_o;
      else if (ir_valid_o && ir_ready_i)
      begin
        check_ir("stream", model_load(SZ_WORD, fetch_pc), ir_o);
        fetch_pc <= fetch_pc + 32'd4;
        taken <= taken + 1;
      end
    end
  end

  initial
  begin
    logic [31:0] rdy_lfsr;
    rdy_lfsr = SEED;
    ir_ready_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      if (stream_on)
      begin
        ir_ready_i <= rdy_lfsr[0];
        rdy_lfsr = lfsr_next(rdy_lfsr);
      end
    end
  end

  initial
  begin
    repeat (LIMIT) @(posedge clk_i);
    abort_run($sformatf("timeout: the run hung and did not end within %0d cycles", LIMIT));
  end

  initial
  begin
    int          kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] sp;
    logic [31:0] tgt;
    logic [31:0] ret;
    mem_size_t   sz;
    rst_i = 1'b1;
    cmd_i = '0;
    cmd_valid_i = 1'b0;
    stall_i = 1'b0;
    model_mem = '{default: 8'h0};
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    // word 0 is already buffered by the fetch unit, so code starts at 4
    for (int i = 1; i <= NCODE; i++)
    begin
      d = rand_bits(32);
      run_cmd(make_cmd(OP_STORE, SZ_WORD, i * 4, d, 32'h0, 32'h0), "code store");
    end
    stream_on = 1'b1;
    for (int n = 0; n < NRAND; n++)
    begin
      kind = rand_bits(3);
      a = 32'h2000 | rand_bits(8);  // data window above the code region
      d = rand_bits(32);
      sp = 32'h2100 + (rand_bits(8) << 2);
      tgt = rand_bits(5) << 2;  // targets fall in the code region
      ret = rand_bits(5) << 2;
      sz = rand_size();
      case (kind)
        3:
          run_cmd(make_cmd(OP_LOAD, sz, a, 32'h0, sp, ret), "load");
        4:
        begin
          run_cmd(make_cmd(OP_PUSH, SZ_WORD, a, d, sp, ret), "push");
          run_cmd(make_cmd(OP_POP, SZ_WORD, a, 32'h0, sp - 32'd4, ret), "pop");
          check_word("pop data", d, result_o);
        end
        5:
        begin
          run_cmd(make_cmd(OP_JSR, SZ_WORD, tgt, 32'h0, sp, ret), "jsr");
          run_cmd(make_cmd(OP_RTS, SZ_WORD, 32'h0, 32'h0, sp - 32'd4, 32'h0), "rts");
          check_word("rts target", ret, pc_o);
        end
        6:
        begin
          run_cmd(make_cmd(OP_TRAP, SZ_WORD, tgt, 32'h0, sp, ret), "trap");
          run_cmd(make_cmd(OP_LOAD, SZ_WORD, sp - 32'd4, 32'h0, sp, ret), "trap frame");
          check_word("trap frame", ret, result_o);
        end
        7:
          run_cmd(make_cmd(OP_NONE, SZ_WORD, a, d, sp, ret), "none");
        default:
          run_cmd(make_cmd(OP_STORE, sz, a, d, sp, ret), "store");
      endcase
    end
    @(negedge clk_i);
    if (taken == 0)
      abort_run("no instruction word was ever taken from the fetch stream");
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
